/* design/lane_result_buffer.sv */
// One result FIFO per execution lane, all popped together
// lane_ready is combinational from each lane's almost_full
// Lane writes are independent, so lanes may skew against each other
`timescale 1ns/1ns
`default_nettype none

`include "simd_upstream_defines.svh"

module lane_result_buffer
  import simd_upstream_pkg::*;
(
  input  wire logic                                  clk,
  input  wire logic                                  rst_n,
  input  wire logic        [`SIMD_NUM_LANES-1:0]     lane_valid,
  input  wire lane_entry_t [`SIMD_NUM_LANES-1:0]     lane_entry,
  output logic             [`SIMD_NUM_LANES-1:0]     lane_ready,
  input  wire logic                                  pop,
  output lane_entry_t      [`SIMD_NUM_LANES-1:0]     head_entries,
  output logic                                       all_lanes_valid
);

  // Head valid per lane, reduced below
  logic [`SIMD_NUM_LANES-1:0] head_valid;
  logic [`SIMD_NUM_LANES-1:0] lane_almost_full;

  // --------------------------------------------------
  // Per-lane FIFOs
  // --------------------------------------------------
  for (genvar i = 0; i < `SIMD_NUM_LANES; i++)
  begin : g_lane

    result_fifo #(
      .DEPTH     (`SIMD_LANE_FIFO_DEPTH),
      .THRESHOLD (`SIMD_LANE_FIFO_THRESHOLD),
      .WIDTH     ($bits(lane_entry_t))
    ) u_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .write       (lane_valid[i]),
      .write_data  (lane_entry[i]),
      .pipe_valid  (head_valid[i]),
      .pipe_data   (head_entries[i]),
      // One pop for every lane, the send FSM moves them in lockstep
      .pipe_read   (pop),
      .almost_full (lane_almost_full[i])
    );

  end

  // Back-pressure toward the execution lanes, no register
  assign lane_ready = ~lane_almost_full;

  // Every lane has a result waiting
  assign all_lanes_valid = &head_valid;

endmodule

`default_nettype wire

/* design/result_fifo.sv */
// Circular buffer FIFO with the head shown as valid/data
// A write shows up as pipe_valid after one edge, pipe_read drops the head at the edge
// Writer has to stop on almost_full as nothing but an assertion guards overflow
// DEPTH need not be a power of two
`timescale 1ns/1ns
`default_nettype none

module result_fifo #(
  parameter int DEPTH     = 8,
  parameter int THRESHOLD = 6,
  parameter int WIDTH     = 32
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             write,
  input  wire logic [WIDTH-1:0] write_data,
  output logic                  pipe_valid,
  output logic      [WIDTH-1:0] pipe_data,
  input  wire logic             pipe_read,
  output logic                  almost_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage array
  logic [WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;

  // --------------------------------------------------
  // Write side
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (write)
    begin
      mem[wr_ptr] <= write_data;
    end
  end

  // Pointers wrap explicitly so any depth works
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (write)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pipe_read)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy holds on a simultaneous write and read
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count <= '0;
    end
    else
    begin
      case ({write, pipe_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------
  // Head and status
  // --------------------------------------------------
  assign pipe_valid  = (count != '0);
  assign pipe_data   = mem[rd_ptr];
  assign full        = (count == CNT_W'(DEPTH));
  // Early warning so writers in flight still fit
  assign almost_full = (count >= CNT_W'(THRESHOLD));

  // Writer ignored almost_full long enough to overflow
  a_no_write_full : assert property (@(posedge clk) disable iff (!rst_n)
    full |-> !write)
    else $error("result_fifo: write while full");

  // Reader popped without a head
  a_no_read_empty : assert property (@(posedge clk) disable iff (!rst_n)
    pipe_read |-> pipe_valid)
    else $error("result_fifo: read while empty");

endmodule

`default_nettype wire

/* design/simd_upstream_pkg.sv */
// Shared types for the SIMD upstream result path
// Lane entries are 34 bits, the upstream packet is 144 bits with 4 lanes
`default_nettype none

`include "simd_upstream_defines.svh"

package simd_upstream_pkg;

  // --------------------------------------------------
  // Stream markers carried with each lane result
  // --------------------------------------------------
  typedef enum logic [1:0] {
    MARK_SOM = 2'b00,  // start of message
    MARK_MOM = 2'b01,  // middle of message
    MARK_EOM = 2'b10,  // end of message
    MARK_SSM = 2'b11   // single word message
  } stream_mark_e;

  // One lane result, marker on top
  typedef struct packed {
    stream_mark_e                  mark;
    logic [`SIMD_LANE_WIDTH-1:0]   data;
  } lane_entry_t;

  // Packet toward the stack upstream interface
  // Lane 0 sits in the low bits
  typedef struct packed {
    logic [`SIMD_TAG_WIDTH-1:0]          tag;
    lane_entry_t [`SIMD_NUM_LANES-1:0]   lanes;
  } upstream_packet_t;

  // --------------------------------------------------
  // Upstream send FSM states
  // --------------------------------------------------
  typedef enum logic [2:0] {
    SEND_WAIT          = 3'd0,
    SEND_DATA          = 3'd1,
    SEND_WAIT_CMPL     = 3'd2,
    SEND_WAIT_CMPL_LOW = 3'd3,
    SEND_CMPL          = 3'd4
  } send_state_e;

endpackage

`default_nettype wire

/* design/simd_upstream_top.sv */
// Result path of the PE SIMD wrapper toward the stack upstream interface
// Lane writers must honor lane_ready, the controller must honor tag_ready
// tag_ready is registered and follows tag FIFO occupancy one cycle late
// up_packet shows the FIFO heads, it is only meaningful while up_valid is high
`timescale 1ns/1ns
`default_nettype none

`include "simd_upstream_defines.svh"

module simd_upstream_top
  import simd_upstream_pkg::*;
(
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  // Execution lane results
  input  wire logic        [`SIMD_NUM_LANES-1:0] lane_valid,
  input  wire lane_entry_t [`SIMD_NUM_LANES-1:0] lane_entry,
  output logic             [`SIMD_NUM_LANES-1:0] lane_ready,
  // Operation tags from the controller
  input  wire logic                              tag_valid,
  input  wire logic        [`SIMD_TAG_WIDTH-1:0] tag,
  output logic                                   tag_ready,
  // Stack upstream interface
  output upstream_packet_t                       up_packet,
  output logic                                   up_valid,
  input  wire logic                              up_ready,
  input  wire logic                              up_complete
);

  logic                              tag_head_valid;
  logic        [`SIMD_TAG_WIDTH-1:0] tag_head;
  logic                              tag_almost_full;
  lane_entry_t [`SIMD_NUM_LANES-1:0] head_entries;
  logic                              all_lanes_valid;
  logic                              pop;

  // --------------------------------------------------
  // Tag FIFO
  // --------------------------------------------------
  // Lets the controller queue the next operation while
  // the current result is still on its way upstream
  result_fifo #(
    .DEPTH     (`SIMD_TAG_FIFO_DEPTH),
    .THRESHOLD (`SIMD_TAG_FIFO_THRESHOLD),
    .WIDTH     (`SIMD_TAG_WIDTH)
  ) u_tag_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .write       (tag_valid),
    .write_data  (tag),
    .pipe_valid  (tag_head_valid),
    .pipe_data   (tag_head),
    .pipe_read   (pop),
    .almost_full (tag_almost_full)
  );

  // Registered ready, low for the first cycle out of reset
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tag_ready <= 1'b0;
    end
    else
    begin
      tag_ready <= ~tag_almost_full;
    end
  end

  // --------------------------------------------------
  // Lane result FIFOs
  // --------------------------------------------------
  lane_result_buffer u_lane_buf (
    .clk             (clk),
    .rst_n           (rst_n),
    .lane_valid      (lane_valid),
    .lane_entry      (lane_entry),
    .lane_ready      (lane_ready),
    .pop             (pop),
    .head_entries    (head_entries),
    .all_lanes_valid (all_lanes_valid)
  );

  // Send FSM, pops tag and all lanes in the send cycle
  upstream_send_fsm u_send_fsm (
    .clk             (clk),
    .rst_n           (rst_n),
    .tag_head_valid  (tag_head_valid),
    .all_lanes_valid (all_lanes_valid),
    .up_ready        (up_ready),
    .up_complete     (up_complete),
    .up_valid        (up_valid),
    .pop             (pop)
  );

  // Packet straight from the heads
  assign up_packet.tag   = tag_head;
  assign up_packet.lanes = head_entries;

endmodule

`default_nettype wire

/* design/upstream_send_fsm.sv */
// Sequences one upstream packet at a time
// up_valid is a single cycle pulse, not a held handshake
// Responder must raise up_complete after taking the packet, then lower it
// up_ready and up_complete are sampled one cycle late
`timescale 1ns/1ns
`default_nettype none

module upstream_send_fsm
  import simd_upstream_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic tag_head_valid,
  input  wire logic all_lanes_valid,
  input  wire logic up_ready,
  input  wire logic up_complete,
  output logic      up_valid,
  output logic      pop
);

  send_state_e state;
  send_state_e state_next;

  logic up_ready_q;
  logic up_complete_q;
  logic packet_ready;

  // --------------------------------------------------
  // One flop on each responder input
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      up_ready_q    <= 1'b0;
      up_complete_q <= 1'b0;
    end
    else
    begin
      up_ready_q    <= up_ready;
      up_complete_q <= up_complete;
    end
  end

  // Tag and a result from each lane are at the heads
  assign packet_ready = tag_head_valid & all_lanes_valid;

  // --------------------------------------------------
  // State register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= SEND_WAIT;
    end
    else
    begin
      state <= state_next;
    end
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      // Hold until a full operation and a ready responder
      SEND_WAIT:
      begin
        if (packet_ready && up_ready_q)
        begin
          state_next = SEND_DATA;
        end
      end
      // Single cycle with the packet out and the heads popped
      SEND_DATA:
        state_next = SEND_WAIT_CMPL;
      // Responder still busy with the packet
      SEND_WAIT_CMPL:
      begin
        if (up_complete_q)
        begin
          state_next = SEND_WAIT_CMPL_LOW;
        end
      end
      // Complete must fall before the next packet
      SEND_WAIT_CMPL_LOW:
      begin
        if (!up_complete_q)
        begin
          state_next = SEND_CMPL;
        end
      end
      SEND_CMPL:
        state_next = SEND_WAIT;
      default:
        state_next = SEND_WAIT;
    endcase
  end

  // Valid and pop share the send state
  assign up_valid = (state == SEND_DATA);
  assign pop      = (state == SEND_DATA);

  // Complete only ever answers a packet that was sent
  a_no_stray_complete : assert property (@(posedge clk) disable iff (!rst_n)
    (state == SEND_WAIT) |-> !up_complete_q)
    else $error("upstream_send_fsm: up_complete high with no packet outstanding");

endmodule

`default_nettype wire

/* dv/simd_upstream_golden.txt */
// One operation per line, all fields hex
// tag mark0 mark1 mark2 mark3 data0 data1 data2 data3 skew0 skew1 skew2 skew3 ready_pattern complete_len
// Marks 0 start, 1 middle, 2 end, 3 single word
// Ready bit i drives up_ready on cycle i of a wait, high after cycle 7
// Skew is the lane write offset in cycles after the tag, before LFSR jitter

// Streamed operations, lanes skewed against each other
11 3 3 3 3 0000a001 0000b002 0000c003 0000d004 0 0 0 0 ff 1
22 0 0 0 0 12345678 9abcdef0 0fedcba9 87654321 3 0 1 2 fc 2
33 1 1 1 1 deadbeef cafef00d 01234567 89abcdef 0 2 0 1 f0 3
44 2 2 2 2 55aa55aa aa55aa55 ffff0000 0000ffff 1 1 3 0 0f 1
55 3 0 1 2 00000001 00000010 00000100 00001000 2 3 0 0 e1 4
66 0 1 2 3 7fffffff 80000000 c0ffee00 00badcab 0 0 0 3 00 2

// Back-pressure fill, written with up_ready held low, skew unused
77 0 0 0 0 a5a5a5a5 5a5a5a5a 3c3c3c3c c3c3c3c3 0 0 0 0 ff 1
88 1 1 1 1 11112222 33334444 55556666 77778888 0 0 0 0 fe 2
99 2 2 2 2 99990000 aaaabbbb ccccdddd eeeeffff 0 0 0 0 ff 1
aa 3 3 3 3 0a0a0a0a 0b0b0b0b 0c0c0c0c 0d0d0d0d 0 0 0 0 f3 3
bb 0 1 1 2 10203040 50607080 90a0b0c0 d0e0f000 0 0 0 0 ff 1
cc 3 2 1 0 fedcba98 76543210 13579bdf 2468ace0 0 0 0 0 ff 2

/* dv/simd_upstream_tb.sv */
// Self-checking testbench for the SIMD upstream result path
// Reads dv/simd_upstream_golden.txt, so it runs from the project root
// Assumes the tag FIFO threshold sits below the lane FIFO threshold
`timescale 1ns/1ns
`default_nettype none

`include "simd_upstream_defines.svh"

module simd_upstream_tb
  import simd_upstream_pkg::*;
();

  localparam int STREAM_OPS = 6;
  localparam int FILL_OPS   = `SIMD_LANE_FIFO_THRESHOLD;
  localparam int NUM_OPS    = STREAM_OPS + FILL_OPS;
  // tag, 4 marks, 4 data, 4 skews, ready pattern, complete length
  localparam int FIELDS     = 15;

  logic                              clk;
  logic                              rst_n;
  logic        [`SIMD_NUM_LANES-1:0] lane_valid;
  lane_entry_t [`SIMD_NUM_LANES-1:0] lane_entry;
  logic        [`SIMD_NUM_LANES-1:0] lane_ready;
  logic                              tag_valid;
  logic        [`SIMD_TAG_WIDTH-1:0] tag;
  logic                              tag_ready;
  upstream_packet_t                  up_packet;
  logic                              up_valid;
  logic                              up_ready;
  logic                              up_complete;

  logic [31:0] golden [NUM_OPS*FIELDS];
  logic [15:0] lfsr_state = 16'd29;
  // Forces the responder to hold up_ready low
  logic        hold_ready;
  // Operations with tag and all lanes written
  int          ops_written;
  // Packets seen and whether one still waits for complete
  int          pkt_idx;
  logic        busy;

  // --------------------------------------------------
  // Golden access and jitter source
  // --------------------------------------------------
  function automatic logic [`SIMD_TAG_WIDTH-1:0] tag_of(int k);
    return golden[k*FIELDS][`SIMD_TAG_WIDTH-1:0];
  endfunction

  function automatic lane_entry_t entry_of(int k, int l);
    lane_entry_t e;
    e.mark = stream_mark_e'(golden[k*FIELDS+1+l][1:0]);
    e.data = golden[k*FIELDS+5+l];
    return e;
  endfunction

  // Tag on top with lane 0 in the low bits
  function automatic upstream_packet_t expected_packet(int k);
    upstream_packet_t p;
    int               l;
    p.tag = tag_of(k);
    for (l = 0; l < `SIMD_NUM_LANES; l++)
      p.lanes[l] = entry_of(k, l);
    return p;
  endfunction

  // Galois form with taps 16 14 13 11
  function automatic logic lfsr_step();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b)
      lfsr_state = lfsr_state ^ 16'hB400;
    return b;
  endfunction

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic fail_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic abort_run(string why);
    $display("ERROR: %s", why);
    fail_run();
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp)
    begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_packet(string name, upstream_packet_t exp, upstream_packet_t act);
    if (act !== exp)
    begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      fail_run();
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  // One write cycle where the valids drop at the capture edge
  task automatic write_once(int k, logic with_tag, logic [`SIMD_NUM_LANES-1:0] mask,
                            logic counts_op);
    int l;
    @(posedge clk);
    tag_valid  <= with_tag;
    tag        <= tag_of(k);
    lane_valid <= mask;
    for (l = 0; l < `SIMD_NUM_LANES; l++)
      lane_entry[l] <= entry_of(k, l);
    @(posedge clk);
    tag_valid  <= 1'b0;
    lane_valid <= '0;
    if (counts_op)
      ops_written++;
    @(negedge clk);
  endtask

  // Tag goes first and each lane follows at its golden skew plus two LFSR bits
  task automatic write_skewed(int k);
    int         skew [`SIMD_NUM_LANES];
    logic [1:0] jit;
    int         l;
    int         t;
    int         last;
    // Room for a whole operation
    do
      @(negedge clk);
    while (!(tag_ready && (&lane_ready)));
    last = 0;
    for (l = 0; l < `SIMD_NUM_LANES; l++)
    begin
      jit[1]  = lfsr_step();
      jit[0]  = lfsr_step();
      skew[l] = int'(golden[k*FIELDS+9+l]) + int'(jit);
      if (skew[l] > last)
        last = skew[l];
    end
    for (t = 0; t <= last; t++)
    begin
      @(posedge clk);
      tag_valid <= (t == 0);
      tag       <= tag_of(k);
      for (l = 0; l < `SIMD_NUM_LANES; l++)
      begin
        lane_valid[l] <= (skew[l] == t);
        lane_entry[l] <= entry_of(k, l);
      end
    end
    @(posedge clk);
    tag_valid  <= 1'b0;
    lane_valid <= '0;
    ops_written++;
  endtask

  // Fill to the thresholds while the responder refuses packets
  task automatic fill_under_backpressure();
    int j;
    int l;
    hold_ready = 1'b1;
    repeat (3) @(negedge clk);
    for (j = 0; j < FILL_OPS; j++)
    begin
      if (j < `SIMD_TAG_FIFO_THRESHOLD)
      begin
        write_once(STREAM_OPS + j, 1'b1, '1, 1'b1);
        check_bit($sformatf("tag_ready after tag write %0d", j + 1), 1'b1, tag_ready);
      end
      else
        write_once(STREAM_OPS + j, 1'b0, '1, 1'b0);
      // Lane ready follows occupancy without a register
      for (l = 0; l < `SIMD_NUM_LANES; l++)
        check_bit($sformatf("lane_ready[%0d] after lane write %0d", l, j + 1),
                  (j + 1 < `SIMD_LANE_FIFO_THRESHOLD), lane_ready[l]);
      if (j == `SIMD_TAG_FIFO_THRESHOLD - 1)
      begin
        @(negedge clk);
        check_bit("tag_ready one cycle after threshold", 1'b0, tag_ready);
      end
    end
    repeat (4) @(negedge clk);
    hold_ready = 1'b0;
    // Late tags for lanes already queued
    for (j = `SIMD_TAG_FIFO_THRESHOLD; j < FILL_OPS; j++)
    begin
      do
        @(negedge clk);
      while (!tag_ready);
      write_once(STREAM_OPS + j, 1'b1, '0, 1'b1);
    end
  endtask

  task automatic wait_drained(int n);
    do
      @(negedge clk);
    while (pkt_idx != n || busy);
  endtask

  simd_upstream_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .lane_valid  (lane_valid),
    .lane_entry  (lane_entry),
    .lane_ready  (lane_ready),
    .tag_valid   (tag_valid),
    .tag         (tag),
    .tag_ready   (tag_ready),
    .up_packet   (up_packet),
    .up_valid    (up_valid),
    .up_ready    (up_ready),
    .up_complete (up_complete)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin : main_seq
    int k;
    int l;
    rst_n      <= 1'b0;
    lane_valid <= '0;
    lane_entry <= '0;
    tag_valid  <= 1'b0;
    tag        <= '0;
    hold_ready  = 1'b0;
    ops_written = 0;
    $readmemh("dv/simd_upstream_golden.txt", golden);
    // Every complete length is at least one
    if ($isunknown(golden[NUM_OPS*FIELDS-1]) || golden[NUM_OPS*FIELDS-1] == 32'd0)
      abort_run("golden data file is missing or too short");
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // Status right out of reset
    @(negedge clk);
    check_bit("up_valid after reset", 1'b0, up_valid);
    for (l = 0; l < `SIMD_NUM_LANES; l++)
      check_bit($sformatf("lane_ready[%0d] after reset", l), 1'b1, lane_ready[l]);
    check_bit("tag_ready first cycle after reset", 1'b0, tag_ready);
    @(negedge clk);
    check_bit("tag_ready second cycle after reset", 1'b1, tag_ready);
    for (k = 0; k < STREAM_OPS; k++)
      write_skewed(k);
    wait_drained(STREAM_OPS);
    fill_under_backpressure();
    wait_drained(NUM_OPS);
    $display("STATUS: PASS");
    $finish;
  end

  // Responder drives the golden ready pattern per packet and then holds complete high
  // for the golden length
  initial
  begin : responder
    int         k;
    int         step;
    int         left;
    logic [7:0] pattern;
    up_ready    <= 1'b0;
    up_complete <= 1'b0;
    k = 0;
    wait (rst_n === 1'b1);
    forever
    begin
      pattern = (k < NUM_OPS) ? golden[k*FIELDS+13][7:0] : 8'hff;
      left    = (k < NUM_OPS) ? int'(golden[k*FIELDS+14]) : 1;
      step    = 0;
      do
      begin
        @(posedge clk);
        up_ready <= !hold_ready && ((step < 8) ? pattern[step] : 1'b1);
        step++;
        @(negedge clk);
      end
      while (up_valid !== 1'b1);
      repeat (left)
      begin
        @(posedge clk);
        up_ready    <= 1'b0;
        up_complete <= 1'b1;
      end
      @(posedge clk);
      up_complete <= 1'b0;
      k++;
    end
  end

  // --------------------------------------------------
  // Packet monitor
  // --------------------------------------------------
  initial
  begin : monitor
    int   low_run;
    logic seen_high;
    low_run   = 0;
    seen_high = 1'b0;
    pkt_idx   = 0;
    busy      = 1'b0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge clk);
      // up_ready is seen two cycles late inside the DUT
      if (low_run >= 2)
        check_bit("up_valid while up_ready low", 1'b0, up_valid);
      if (up_valid)
      begin
        check_bit("up_valid before complete handshake", 1'b0, busy);
        if (pkt_idx >= NUM_OPS)
          abort_run("extra packet on the upstream interface");
        if (pkt_idx >= ops_written)
          abort_run($sformatf("packet %0d sent before its tag and lanes were written",
                              pkt_idx));
        check_packet($sformatf("packet %0d", pkt_idx), expected_packet(pkt_idx), up_packet);
        pkt_idx++;
        busy      = 1'b1;
        seen_high = 1'b0;
      end
      else if (busy)
      begin
        if (up_complete)
          seen_high = 1'b1;
        else if (seen_high)
          busy = 1'b0;
      end
      low_run = up_ready ? 0 : low_run + 1;
    end
  end

  // Bounded by 200 cycles per golden operation
  initial
  begin : watchdog
    repeat (200 * NUM_OPS + 100) @(posedge clk);
    abort_run("watchdog timeout, not all packets arrived in time");
  end

endmodule

`default_nettype wire

/* include/simd_upstream_defines.svh */
// Sizing for the SIMD result path toward the stack upstream interface
// FIFO depths need not be powers of two
// Tag threshold sits one below the lane threshold since tag ready is registered
`ifndef SIMD_UPSTREAM_DEFINES_SVH
`define SIMD_UPSTREAM_DEFINES_SVH

// --------------------------------------------------
// Lane geometry
// --------------------------------------------------
`define SIMD_NUM_LANES            4
`define SIMD_LANE_WIDTH           32
`define SIMD_TAG_WIDTH            8

// --------------------------------------------------
// Result FIFOs, one per execution lane
// --------------------------------------------------
`define SIMD_LANE_FIFO_DEPTH      8
`define SIMD_LANE_FIFO_THRESHOLD  6

// --------------------------------------------------
// Tag FIFO from the controller
// --------------------------------------------------
`define SIMD_TAG_FIFO_DEPTH       8
`define SIMD_TAG_FIFO_THRESHOLD   5

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the SIMD upstream testbench with Verilator
# The verdict comes from the pass line in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module simd_upstream_tb --Mdir obj_dir \
  -f simd_upstream.f > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vsimd_upstream_tb 2>&1 | tee sim.log

grep -qx "STATUS: PASS" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* simd_upstream.f */
+incdir+include
design/simd_upstream_pkg.sv
design/result_fifo.sv
design/lane_result_buffer.sv
design/upstream_send_fsm.sv
design/simd_upstream_top.sv
dv/simd_upstream_tb.sv
